// File: fp_add_cfg.svh
`ifndef FP_ADD_CFG_SVH
`define FP_ADD_CFG_SVH

// single precision field widths
`define FP_EXP_W   8
`define FP_FRAC_W  23

// fraction plus the hidden leading one
`define FP_MANT_W  24

// all-ones exponent, reserved for infinity
`define FP_EXP_MAX 255

`endif

// File: fp_add_unit.f
+incdir+.
fp_types_pkg.sv
fp_ctrl_pkg.sv
fp_align.sv
fp_addsub.sv
fp_normalize.sv
fp_req_ctrl.sv
fp_add_unit.sv
fp_add_unit_properties.sv
fp_add_unit_tb.sv

// File: fp_add_unit.sv
`timescale 1ns/1ps

module fp_add_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    output logic                       ack,
    input  fp_types_pkg::fp_operands_t operands,
    output fp_ctrl_pkg::fp_result_t    result
);
    import fp_types_pkg::*;
    import fp_ctrl_pkg::*;

    // stage to stage links
    fp_operands_t held;
    fp_aligned_t  aligned;
    fp_raw_sum_t  raw;
    fp_result_t   calc_res;

    // handshake and the operand/result registers
    fp_req_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .ack      (ack),
        .operands (operands),
        .held     (held),
        .calc_res (calc_res),
        .result   (result)
    );

    // combinational datapath between the registers
    fp_align u_align (
        .operands (held),
        .aligned  (aligned)
    );

    fp_addsub u_addsub (
        .aligned (aligned),
        .raw     (raw)
    );

    fp_normalize u_norm (
        .raw (raw),
        .res (calc_res)
    );

endmodule

// File: fp_add_unit_properties.sv
`timescale 1ns/1ps

module fp_add_unit_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    req,
    input logic                    ack,
    input fp_ctrl_pkg::fp_result_t result
);

    // ack only answers a req seen on the edge before
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    // req rose two samples back, ack must be up by now
    a_ack_within_two: assert property (@(posedge clk) disable iff (rst)
        ($past(req, 2) && !$past(req, 3)) |-> ack)
        else $error("ack did not follow req within two cycles");

    // result frozen for as long as ack stays high
    a_result_held: assert property (@(posedge clk) disable iff (rst)
        (ack && $past(ack)) |-> $stable(result))
        else $error("result changed while ack was high");

    a_ack_low_after_reset: assert property (@(posedge clk)
        rst |=> !ack)
        else $error("ack high after reset");

endmodule

bind fp_add_unit fp_add_unit_properties u_props (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .ack    (ack),
    .result (result)
);

// File: fp_add_unit_tb.sv
`timescale 1ns/1ps

module fp_add_unit_tb;
    import fp_types_pkg::*;
    import fp_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 40;
    localparam int ACK_TIMEOUT  = 8;

    // one directed case, hold is extra cycles of req after ack
    typedef struct {
        string      name;
        fp_word_t   a;
        fp_word_t   b;
        fp_result_t expected;
        int         hold;
    } case_t;

    logic         clk;
    logic         rst;
    logic         req;
    logic         ack;
    fp_operands_t operands;
    fp_result_t   result;

    case_t       cases[$];
    logic [31:0] lfsr;
    int          pass_count;
    int          fail_count;

    fp_add_unit uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // reference adder on signed integers, truncating, denormals flushed
    function automatic fp_result_t model_add(input fp_word_t a, input fp_word_t b);
        fp_result_t r;
        int         ea;
        int         eb;
        int         e;
        longint     ma;
        longint     mb;
        longint     sum;
        longint     mag;
        logic       neg;
        r  = '0;
        ea = a[30:23];
        eb = b[30:23];
        if (ea == 0 && eb == 0) begin
            return r;
        end
        if (ea == 0 || eb == 0) begin
            r.value = (ea == 0) ? b : a;
            return r;
        end
        ma = {1'b1, a[22:0]};
        mb = {1'b1, b[22:0]};
        e  = (ea >= eb) ? ea : eb;
        // smaller side slides down, 24 or more leaves nothing
        if (ea >= eb) begin
            mb = (ea - eb >= 24) ? 0 : (mb >> (ea - eb));
        end else begin
            ma = (eb - ea >= 24) ? 0 : (ma >> (eb - ea));
        end
        if (a[31]) ma = -ma;
        if (b[31]) mb = -mb;
        sum = ma + mb;
        if (sum == 0) begin
            return r;
        end
        neg = (sum < 0);
        mag = neg ? -sum : sum;
        while (mag >= (1 << 24)) begin
            mag = mag >> 1;
            e++;
        end
        while (mag < (1 << 23)) begin
            mag = mag << 1;
            e--;
        end
        if (e >= 255) begin
            r.value          = {neg, 8'hff, 23'h0};
            r.flags.overflow = 1'b1;
        end else if (e <= 0) begin
            r.flags.underflow = 1'b1;
        end else begin
            r.value = {neg, e[7:0], mag[22:0]};
        end
        return r;
    endfunction

    function automatic void add_case(input string name, input fp_word_t a, input fp_word_t b,
                                     input fp_word_t value, input fp_flags_t flags,
                                     input int hold);
        case_t c;
        c.name           = name;
        c.a              = a;
        c.b              = b;
        c.expected.value = value;
        c.expected.flags = flags;
        c.hold           = hold;
        cases.push_back(c);
    endfunction

    // expected words worked out by hand from the format rules
    function automatic void build_table();
        add_case("add_carry_1p5", 32'h3fc00000, 32'h3fc00000, 32'h40400000, 2'b00, 0);
        add_case("add_shift_0p25", 32'h3f800000, 32'h3e800000, 32'h3fa00000, 2'b00, 1);
        add_case("sub_norm_left", 32'h3f800000, 32'hbf400000, 32'h3e800000, 2'b00, 2);
        add_case("sub_larger_neg", 32'hc0000000, 32'h3f000000, 32'hbfc00000, 2'b00, 0);
        add_case("cancel_exact", 32'h40400000, 32'hc0400000, 32'h00000000, 2'b00, 0);
        add_case("zero_plus_x", 32'h00000000, 32'h40490fdb, 32'h40490fdb, 2'b00, 0);
        add_case("denormal_plus_x", 32'h00012345, 32'hc1200000, 32'hc1200000, 2'b00, 3);
        add_case("zero_plus_zero", 32'h80000000, 32'h00000000, 32'h00000000, 2'b00, 0);
        add_case("diff_24_shift_out", 32'h4b800000, 32'h3f800000, 32'h4b800000, 2'b00, 0);
        add_case("overflow_pos", 32'h7f7fffff, 32'h7f7fffff, 32'h7f800000, 2'b10, 0);
        add_case("overflow_neg", 32'hff000000, 32'hff000000, 32'hff800000, 2'b10, 1);
        add_case("underflow_cancel", 32'h00800001, 32'h80800000, 32'h00000000, 2'b01, 0);
        add_case("hold_back_pressure", 32'h40000000, 32'h40000000, 32'h40800000, 2'b00, 5);
    endfunction

    // four-phase transfer, got is the result seen once ack is up
    task automatic run_handshake(input fp_word_t a, input fp_word_t b, input int hold,
                                 output fp_result_t got, output bit ok);
        int waited;
        ok = 1'b1;
        @(negedge clk);
        operands.a = a;
        operands.b = b;
        req        = 1'b1;
        waited     = 0;
        while (!ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (ack) else begin
            $display("no ack from the DUT within %0d cycles of req", ACK_TIMEOUT);
            ok = 1'b0;
        end
        got = result;
        // requester stalls, ack and result must not move
        repeat (hold) begin
            @(negedge clk);
            assert (ack && result == got) else begin
                $display("ack or result changed while req was still high");
                ok = 1'b0;
            end
        end
        req    = 1'b0;
        waited = 0;
        while (ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (!ack) else begin
            $display("ack stayed high after req was lowered");
            ok = 1'b0;
        end
    endtask

    task automatic apply_case(input string name, input fp_word_t a, input fp_word_t b,
                              input fp_result_t expected, input int hold);
        fp_result_t got;
        bit         hs_ok;
        bit         value_ok;
        run_handshake(a, b, hold, got, hs_ok);
        value_ok = hs_ok;
        if (hs_ok) begin
            assert (got == expected) else begin
                $display("FAIL %s expected %h flags %b actual %h flags %b", name,
                         expected.value, expected.flags, got.value, got.flags);
                value_ok = 1'b0;
            end
        end else begin
            $display("FAIL %s the handshake did not complete cleanly", name);
        end
        if (value_ok) begin
            $display("PASS %s", name);
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    // after reset nothing moves until a request shows up
    task automatic check_idle();
        bit ok;
        ok = 1'b1;
        assert (!ack && result == '0) else begin
            $display("ack or result not cleared by reset");
            ok = 1'b0;
        end
        repeat (4) begin
            @(negedge clk);
            assert (!ack) else begin
                $display("ack went high with no request pending");
                ok = 1'b0;
            end
        end
        if (ok) begin
            $display("PASS reset_and_idle");
            pass_count++;
        end else begin
            $display("FAIL reset_and_idle ack was not quiet without req");
            fail_count++;
        end
    endtask

    task automatic run_random(input int count);
        fp_word_t a;
        fp_word_t b;
        for (int i = 0; i < count; i++) begin
            a = take_bits(32);
            b = take_bits(32);
            // about half the draws keep the exponents close so mantissas overlap
            if (take_bits(1) == 1) begin
                b[30:23] = a[30:23] ^ 8'(take_bits(3));
            end
            // exponent 255 is never sent
            if (a[30:23] == 8'hff) a[30:23] = 8'hfe;
            if (b[30:23] == 8'hff) b[30:23] = 8'hfe;
            apply_case($sformatf("random_%0d", i), a, b, model_add(a, b), i % 3);
        end
    endtask

    initial begin
        rst        = 1'b1;
        req        = 1'b0;
        operands   = '0;
        lfsr       = 32'hf250;
        pass_count = 0;
        fail_count = 0;
        build_table();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        check_idle();
        foreach (cases[i]) begin
            apply_case(cases[i].name, cases[i].a, cases[i].b,
                       cases[i].expected, cases[i].hold);
        end
        run_random(NUM_RANDOM);
        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // ten clock periods per case
    initial begin
        int limit_ns;
        #1;
        limit_ns = (cases.size() + NUM_RANDOM) * 10 * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: fp_addsub.sv
`timescale 1ns/1ps

module fp_addsub (
    input  fp_types_pkg::fp_aligned_t aligned,
    output fp_types_pkg::fp_raw_sum_t raw
);
    import fp_types_pkg::*;

    // zero-extended so the add keeps its carry
    fp_sum_t ext_a;
    fp_sum_t ext_b;

    assign ext_a = {1'b0, aligned.mant_a};
    assign ext_b = {1'b0, aligned.mant_b};

    always_comb begin
        // exponent and zero bypass ride along unchanged
        raw.big_exp   = aligned.big_exp;
        raw.zero_case = aligned.zero_case;
        raw.bypass    = aligned.bypass;

        if (aligned.sign_a == aligned.sign_b) begin
            // like signs, magnitudes add
            raw.sum  = ext_a + ext_b;
            raw.sign = aligned.sign_a;
        end else if (ext_a > ext_b) begin
            raw.sum  = ext_a - ext_b;
            raw.sign = aligned.sign_a;
        end else if (ext_b > ext_a) begin
            raw.sum  = ext_b - ext_a;
            raw.sign = aligned.sign_b;
        end else begin
            // exact cancellation is +0
            raw.sum  = '0;
            raw.sign = 1'b0;
        end
    end

endmodule

// File: fp_align.sv
`timescale 1ns/1ps
`include "fp_add_cfg.svh"

module fp_align (
    input  fp_types_pkg::fp_operands_t operands,
    output fp_types_pkg::fp_aligned_t  aligned
);
    import fp_types_pkg::*;

    fp_exp_t  exp_a;
    fp_exp_t  exp_b;
    fp_exp_t  exp_diff;
    fp_mant_t mant_a;
    fp_mant_t mant_b;
    logic     zero_a;
    logic     zero_b;

    // right shift, anything at or past the mantissa width clears it
    function automatic fp_mant_t shift_clamp(input fp_mant_t m, input fp_exp_t d);
        if (d >= `FP_MANT_W) begin
            return '0;
        end
        return m >> d;
    endfunction

    // field extraction
    assign exp_a  = operands.a[`FP_EXP_W+`FP_FRAC_W-1:`FP_FRAC_W];
    assign exp_b  = operands.b[`FP_EXP_W+`FP_FRAC_W-1:`FP_FRAC_W];
    assign mant_a = {1'b1, operands.a[`FP_FRAC_W-1:0]};
    assign mant_b = {1'b1, operands.b[`FP_FRAC_W-1:0]};

    // exponent zero means zero, denormals flushed
    assign zero_a = (exp_a == '0);
    assign zero_b = (exp_b == '0);

    always_comb begin
        aligned.sign_a    = operands.a[`FP_EXP_W+`FP_FRAC_W];
        aligned.sign_b    = operands.b[`FP_EXP_W+`FP_FRAC_W];
        aligned.zero_case = zero_a | zero_b;

        // other operand passes through, two zeros give +0
        if (zero_a && zero_b) begin
            aligned.bypass = '0;
        end else if (zero_a) begin
            aligned.bypass = operands.b;
        end else begin
            aligned.bypass = operands.a;
        end

        // keep larger exponent, shift the smaller side down
        if (exp_a >= exp_b) begin
            exp_diff        = exp_a - exp_b;
            aligned.big_exp = exp_a;
            aligned.mant_a  = mant_a;
            aligned.mant_b  = shift_clamp(mant_b, exp_diff);
        end else begin
            exp_diff        = exp_b - exp_a;
            aligned.big_exp = exp_b;
            aligned.mant_a  = shift_clamp(mant_a, exp_diff);
            aligned.mant_b  = mant_b;
        end
    end

endmodule

// File: fp_ctrl_pkg.sv
package fp_ctrl_pkg;

    // exception flags returned with each result
    typedef struct packed {
        logic overflow;
        logic underflow;
    } fp_flags_t;

    typedef struct packed {
        fp_types_pkg::fp_word_t value;
        fp_flags_t              flags;
    } fp_result_t;

    // four-phase handshake controller states
    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } req_state_e;

endpackage

// File: fp_normalize.sv
`timescale 1ns/1ps
`include "fp_add_cfg.svh"

module fp_normalize (
    input  fp_types_pkg::fp_raw_sum_t raw,
    output fp_ctrl_pkg::fp_result_t   res
);
    import fp_types_pkg::*;
    import fp_ctrl_pkg::*;

    // leading zeros below the hidden bit position
    logic [4:0]        lz;
    fp_mant_t          norm_mant;
    // two extra bits so carry and underflow stay visible
    logic signed [9:0] norm_exp;
    fp_exp_t           exp_field;
    fp_word_t          value;
    fp_flags_t         flags;

    // highest set bit wins, scanning upward
    always_comb begin
        lz = '0;
        for (int i = 0; i < `FP_MANT_W; i++) begin
            if (raw.sum[i]) begin
                lz = 5'(`FP_MANT_W - 1 - i);
            end
        end
    end

    always_comb begin
        if (raw.sum[`FP_MANT_W]) begin
            // carry out, one step right
            norm_mant = raw.sum[`FP_MANT_W:1];
            norm_exp  = $signed({2'b00, raw.big_exp}) + 10'sd1;
        end else begin
            // bring leading one up to the hidden bit
            norm_mant = raw.sum[`FP_MANT_W-1:0] << lz;
            norm_exp  = $signed({2'b00, raw.big_exp}) - $signed({5'b00000, lz});
        end
    end

    always_comb begin
        flags     = '0;
        exp_field = norm_exp[`FP_EXP_W-1:0];
        // extra low bits dropped, truncation only
        value     = {raw.sign, exp_field, norm_mant[`FP_FRAC_W-1:0]};

        if (raw.zero_case) begin
            value = raw.bypass;
        end else if (raw.sum == '0) begin
            // cancelled to nothing, plain +0
            value = '0;
        end else if (norm_exp >= `FP_EXP_MAX) begin
            // signed infinity
            exp_field      = fp_exp_t'(`FP_EXP_MAX);
            value          = {raw.sign, exp_field, {`FP_FRAC_W{1'b0}}};
            flags.overflow = 1'b1;
        end else if (norm_exp <= 0) begin
            // below normal range, flush to +0
            value           = '0;
            flags.underflow = 1'b1;
        end
    end

    assign res = '{value: value, flags: flags};

endmodule

// File: fp_req_ctrl.sv
`timescale 1ns/1ps

module fp_req_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    output logic                       ack,
    input  fp_types_pkg::fp_operands_t operands,
    output fp_types_pkg::fp_operands_t held,
    input  fp_ctrl_pkg::fp_result_t    calc_res,
    output fp_ctrl_pkg::fp_result_t    result
);
    import fp_ctrl_pkg::*;

    req_state_e state;
    req_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            // wait for a request
            IDLE: begin
                if (req) begin
                    state_next = CALC;
                end
            end
            // datapath settles in one cycle
            CALC: state_next = DONE;
            // hold until requester drops req
            DONE: begin
                if (!req) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // operands latched on the edge that sees req
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            held <= operands;
        end
    end

    // result loads on entry to DONE, then held through back-pressure
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (state == CALC) begin
            result <= calc_res;
        end
    end

    // ack only while the result is valid
    assign ack = (state == DONE);

endmodule

// File: fp_types_pkg.sv
`include "fp_add_cfg.svh"

package fp_types_pkg;

    // packed ieee word: sign, exponent, fraction
    typedef logic [`FP_EXP_W+`FP_FRAC_W:0] fp_word_t;

    // biased exponent
    typedef logic [`FP_EXP_W-1:0] fp_exp_t;

    // mantissa with hidden one restored
    typedef logic [`FP_MANT_W-1:0] fp_mant_t;

    // one extra bit to keep the add carry
    typedef logic [`FP_MANT_W:0] fp_sum_t;

    typedef struct packed {
        fp_word_t a;
        fp_word_t b;
    } fp_operands_t;

    // alignment output, mantissas already on the common exponent
    typedef struct packed {
        logic     sign_a;
        logic     sign_b;
        fp_exp_t  big_exp;
        fp_mant_t mant_a;
        fp_mant_t mant_b;
        logic     zero_case;
        fp_word_t bypass;
    } fp_aligned_t;

    // signed add output, not yet normalized
    typedef struct packed {
        logic     sign;
        fp_exp_t  big_exp;
        fp_sum_t  sum;
        logic     zero_case;
        fp_word_t bypass;
    } fp_raw_sum_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run fp_add_unit_tb with Verilator, pass or fail decided from the log

cd "$(dirname "$0")" || exit 1

log=sim.log
build=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module fp_add_unit_tb -f fp_add_unit.f --Mdir "$build" -o fp_add_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build/fp_add_unit_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$log"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
